//--- project.f
design/uart_link_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_controller.sv
design/uart_link_top.sv
test/tb_clock_gen.sv
test/tb_checker.sv
test/tb_uart_link.sv

//--- run.sh
#!/bin/sh
# compile and run the host-link UART testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f project.f --top-module tb_uart_link -o sim_uart_link
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_uart_link > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation run failed"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0

//--- test/tb_uart_link.sv
/*
  testbench top for the host-link UART
  - stimulus table applied in a loop, serial host driver
  - lfsr payloads, watchdog, DUT and checker
*/
module tb_uart_link;
  timeunit 1ns;
  timeprecision 1ps;

  import uart_link_pkg::*;

  localparam int max_tests = 16;
  localparam int bit_clks  = int'(clks_per_bit);

  logic       clk;
  logic       rst;
  logic       rxd;
  logic       core_busy;
  logic       tx_valid;
  core_word_t tx_word;
  logic       txd;
  logic       tx_ready;
  logic       rx_valid;
  cmd_word_t  rx_cmd;

  // stimulus table
  string       t_name  [max_tests];
  bit          t_core  [max_tests]; // core word rather than host bytes
  bit          t_busy  [max_tests];
  int          t_nbytes[max_tests]; // host bytes right aligned in t_stim
  logic [31:0] t_stim  [max_tests];
  int          t_exp_n [max_tests]; // pulses or frame bytes expected
  logic [31:0] t_exp   [max_tests];
  bit          t_rnd   [max_tests]; // payload from the lfsr
  int          n_tests     = 0;
  bit          table_ready = 1'b0;
  logic [31:0] lfsr_state;

  tb_clock_gen clk_gen (.o_CLK(clk), .o_RST(rst));

  uart_link_top dut (
    .i_CLK                (clk),
    .i_RST                (rst),
    .i_uart_rxd           (rxd),
    .i_core_busy          (core_busy),
    .i_uart_data_tx       (tx_word),
    .i_uart_data_tx_valid (tx_valid),
    .o_uart_txd           (txd),
    .o_uart_data_tx_ready (tx_ready),
    .o_uart_data_rx       (rx_cmd),
    .o_uart_data_rx_valid (rx_valid)
  );

  tb_checker chk (
    .i_CLK      (clk),
    .i_RST      (rst),
    .i_txd      (txd),
    .i_tx_ready (tx_ready),
    .i_rx_valid (rx_valid),
    .i_rx_cmd   (rx_cmd)
  );

  // ========================================
  // table and lfsr
  // ========================================
  task automatic host_entry(input string name, input bit busy, input int nb,
                            input logic [15:0] bytes, input int exp_n,
                            input logic [15:0] cmd, input bit rnd);
    t_name[n_tests]   = name;
    t_core[n_tests]   = 1'b0;
    t_busy[n_tests]   = busy;
    t_nbytes[n_tests] = nb;
    t_stim[n_tests]   = {16'h0000, bytes};
    t_exp_n[n_tests]  = exp_n;
    t_exp[n_tests]    = {16'h0000, cmd};
    t_rnd[n_tests]    = rnd; // last byte is the address
    n_tests++;
  endtask

  task automatic core_entry(input string name, input logic [31:0] word, input int exp_n);
    t_name[n_tests]   = name;
    t_core[n_tests]   = 1'b1;
    t_busy[n_tests]   = 1'b0;
    t_nbytes[n_tests] = 0;
    t_stim[n_tests]   = word;
    t_exp_n[n_tests]  = exp_n;
    t_exp[n_tests]    = word; // frame is the word sent msb first
    t_rnd[n_tests]    = 1'b1; // low 3 bytes random
    n_tests++;
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v          = {v[30:0], lfsr_state[0]};
    end
  endtask

  // ========================================
  // drivers
  // ========================================
  task automatic send_byte(input uart_byte_t b);
    uart_byte_t sh;
    sh  = b;
    rxd = 1'b0; // start bit
    repeat (bit_clks) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rxd = sh[0];
      sh  = sh >> 1;
      repeat (bit_clks) @(negedge clk);
    end
    rxd = 1'b1; // stop bit plus 2 idle bits
    repeat (3 * bit_clks) @(negedge clk);
  endtask

  task automatic run_host(input int idx);
    core_busy = t_busy[idx];
    @(negedge clk);
    for (int i = 0; i < t_nbytes[idx]; i++)
      send_byte(uart_byte_t'(t_stim[idx] >> (8 * (t_nbytes[idx] - 1 - i))));
    for (int k = 0; k < 4 * bit_clks; k++) begin // bounded wait for the pulse
      if (chk.rx_count >= t_exp_n[idx]) break;
      @(negedge clk);
    end
  endtask

  task automatic run_core(input int idx);
    core_busy = t_busy[idx];
    tx_word   = t_stim[idx];
    tx_valid  = 1'b1;
    @(negedge clk);
    while (tx_ready) @(negedge clk); // ready low means the word was taken
    tx_valid = 1'b0;
    while (!tx_ready) @(negedge clk); // frame finished
    repeat (bit_clks) @(negedge clk);
  endtask

  // ========================================
  // main sequence and watchdog
  // ========================================
  initial begin : main
    logic [31:0] r;
    rxd        = 1'b1;
    core_busy  = 1'b0;
    tx_valid   = 1'b0;
    tx_word    = '0;
    lfsr_state = 32'd87756;
    host_entry("run_idle",        1'b0, 1, {8'h00, sg_run},          1, {sg_run, 8'h00}, 1'b0);
    host_entry("mpr_read_idle",   1'b0, 2, {sg_mpr_read_reg, 8'h00}, 1,
               {sg_mpr_read_reg, 8'h00}, 1'b1);
    host_entry("ads_read_idle",   1'b0, 2, {sg_ads_read_reg, 8'h00}, 1,
               {sg_ads_read_reg, 8'h00}, 1'b1);
    host_entry("stop_busy",       1'b1, 1, {8'h00, sg_stop}, 1, {sg_stop, 8'h00}, 1'b0);
    host_entry("ads_finish_busy", 1'b1, 1, {8'h00, sg_ads_finish}, 1,
               {sg_ads_finish, 8'h00}, 1'b0);
    host_entry("mpr_finish_busy", 1'b1, 1, {8'h00, sg_mpr_finish}, 1,
               {sg_mpr_finish, 8'h00}, 1'b0);
    host_entry("run_busy",        1'b1, 1, {8'h00, sg_run},          0, 16'h0000, 1'b0);
    host_entry("mpr_read_busy",   1'b1, 2, {sg_mpr_read_reg, 8'h12}, 0,
               16'h0000, 1'b0); // 12 must not be taken as an address
    host_entry("junk_then_run",   1'b0, 2, {8'h5A, sg_run},          1, {sg_run, 8'h00}, 1'b0);
    core_entry("ads_frame",     {sg_ads_send_data, 24'h000000}, 4);
    core_entry("mpr_frame",     {sg_mpr_send_data, 24'h000000}, 3);
    core_entry("mpr_reg_frame", {sg_mpr_read_reg, 24'h000000},  3);
    core_entry("ads_reg_frame", {sg_ads_read_reg, 24'h000000},  3);
    core_entry("unknown_frame", {8'h3C, 24'h000000},            0); // dropped
    table_ready = 1'b1;
    @(negedge rst);
    @(negedge clk);
    while (!tx_ready) @(negedge clk); // idle reached
    for (int idx = 0; idx < n_tests; idx++) begin
      if (t_rnd[idx] && t_core[idx]) begin
        draw_bits(24, r);
        t_stim[idx][23:0] = r[23:0];
        t_exp[idx]        = t_stim[idx];
      end else if (t_rnd[idx]) begin
        draw_bits(8, r);
        t_stim[idx][7:0] = r[7:0];
        t_exp[idx][7:0]  = r[7:0]; // address in the low half
      end
      chk.start_test(t_name[idx], t_core[idx], t_exp_n[idx], t_exp[idx]);
      if (t_core[idx])
        run_core(idx);
      else
        run_host(idx);
      chk.end_test();
    end
    chk.report();
    if (chk.n_fail == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    int total;
    int limit_ns;
    wait (table_ready);
    total = 0;
    for (int i = 0; i < n_tests; i++)
      total += t_core[i] ? t_exp_n[i] : t_nbytes[i];
    limit_ns = total * 10 * bit_clks * 20 * 2 + 20000; // bytes x bits x clocks x ns x 2 plus margin
    #(limit_ns);
    $display("timeout: the tests did not finish within %0d ns", limit_ns);
    $display("Simulation failed");
    $finish;
  end
endmodule

//--- test/tb_checker.sv
/*
  testbench checker
  - decodes the tx line at bit midpoints, records command pulses
  - compares each test against its expectations, keeps the counts
*/
module tb_checker (
  input logic                     i_CLK,
  input logic                     i_RST,
  input logic                     i_txd,
  input logic                     i_tx_ready,
  input logic                     i_rx_valid,
  input uart_link_pkg::cmd_word_t i_rx_cmd
);
  timeunit 1ns;
  timeprecision 1ps;

  import uart_link_pkg::*;

  localparam int bit_clks = int'(clks_per_bit);

  string       cur_name;
  bit          cur_core;  // set for a frame test
  int          cur_n;     // expected pulses or frame bytes
  logic [31:0] cur_exp;
  uart_byte_t  tx_q[$];   // bytes seen on the tx line
  cmd_word_t   rx_q[$];   // command words seen
  int          rx_count;
  bit          ready_bad; // start bit seen with ready high
  bit          stop_bad;  // stop bit sampled low
  int          n_pass = 0;
  int          n_fail = 0;

  // ========================================
  // monitors
  // ========================================
  initial begin : tx_monitor
    uart_byte_t b;
    forever begin
      @(negedge i_txd); // start bit
      if (i_tx_ready) ready_bad = 1'b1;
      repeat (bit_clks / 2) @(negedge i_CLK); // start midpoint
      for (int i = 0; i < 8; i++) begin
        repeat (bit_clks) @(negedge i_CLK);
        b = {i_txd, b[7:1]}; // lsb first
      end
      repeat (bit_clks) @(negedge i_CLK); // stop midpoint
      if (!i_txd) stop_bad = 1'b1;
      tx_q.push_back(b);
    end
  end

  always @(negedge i_CLK) begin
    if (!i_RST && i_rx_valid) begin
      rx_q.push_back(i_rx_cmd);
      rx_count++;
    end
  end

  // ========================================
  // per-test compare
  // ========================================
  task automatic start_test(input string name, input bit core, input int n,
                            input logic [31:0] exp_val);
    cur_name  = name;
    cur_core  = core;
    cur_n     = n;
    cur_exp   = exp_val;
    ready_bad = 1'b0;
    stop_bad  = 1'b0;
    rx_count  = 0;
    tx_q.delete();
    rx_q.delete();
  endtask

  task automatic end_test();
    string       msg;
    logic [31:0] w;
    int          tx_exp;
    int          rx_exp;
    msg    = "";
    w      = cur_exp;
    tx_exp = cur_core ? cur_n : 0;
    rx_exp = cur_core ? 0 : cur_n;
    if (cur_core) begin
      for (int i = 0; i < cur_n && msg == ""; i++) begin
        if (i >= tx_q.size())
          msg = $sformatf("%s: frame byte %0d never appeared on the tx line", cur_name, i);
        else if (tx_q[i] != w[31:24])
          msg = $sformatf("Mismatch %s: expected %h, actual %h", cur_name, w[31:24], tx_q[i]);
        w = w << 8; // msb first
      end
      if (msg == "" && ready_bad)
        msg = $sformatf("%s: ready was high while a frame was sent", cur_name);
      if (msg == "" && stop_bad)
        msg = $sformatf("%s: a stop bit on the tx line was low", cur_name);
    end else if (cur_n > 0) begin
      if (rx_q.size() == 0)
        msg = $sformatf("%s: no command pulse was seen", cur_name);
      else if (rx_q[0] != cur_exp[15:0])
        msg = $sformatf("Mismatch %s: expected %h, actual %h", cur_name, cur_exp[15:0], rx_q[0]);
    end
    if (msg == "" && tx_q.size() > tx_exp)
      msg = $sformatf("%s: unexpected extra byte %h on the tx line", cur_name, tx_q[tx_exp]);
    if (msg == "" && rx_q.size() > rx_exp)
      msg = $sformatf("%s: unexpected command pulse %h", cur_name, rx_q[rx_exp]);
    if (msg == "") begin
      n_pass++;
      $display("ok   %s", cur_name);
    end else begin
      n_fail++;
      $display("%s", msg);
    end
  endtask

  task automatic report();
    $display("tests: %0d passed, %0d failed", n_pass, n_fail);
  endtask
endmodule

//--- test/tb_clock_gen.sv
/*
  testbench clock and reset
  20 ns period, reset held over the first 2 rising edges
*/
module tb_clock_gen (
  output logic o_CLK,
  output logic o_RST
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    o_CLK = 1'b0;
    forever #10 o_CLK = ~o_CLK; // 50 MHz
  end

  initial begin
    o_RST = 1'b1;
    repeat (2) @(posedge o_CLK);
    @(negedge o_CLK); // release on a falling edge
    o_RST = 1'b0;
  end
endmodule

//--- design/uart_link_top.sv
/*
  host-link UART top
  receiver -> controller -> transmitter
*/
module uart_link_top (
  input  logic                      i_CLK,
  input  logic                      i_RST,
  input  logic                      i_uart_rxd,
  input  logic                      i_core_busy,
  input  uart_link_pkg::core_word_t i_uart_data_tx,
  input  logic                      i_uart_data_tx_valid,
  output logic                      o_uart_txd,
  output logic                      o_uart_data_tx_ready,
  output uart_link_pkg::cmd_word_t  o_uart_data_rx,
  output logic                      o_uart_data_rx_valid
);

  import uart_link_pkg::*;

  logic       rx_dv;   // host byte strobe
  uart_byte_t rx_byte;
  logic       tx_dv;   // byte to serializer
  uart_byte_t tx_byte;
  logic       tx_done; // serializer finished stop bit

  uart_rx #(.CLKS_PER_BIT(clks_per_bit)) u_rx (
    .i_CLK     (i_CLK),
    .i_RST     (i_RST),
    .i_rxd     (i_uart_rxd),
    .o_rx_dv   (rx_dv),
    .o_rx_byte (rx_byte)
  );

  uart_controller u_ctrl (
    .i_CLK           (i_CLK),
    .i_RST           (i_RST),
    .i_core_busy     (i_core_busy),
    .i_rx_dv         (rx_dv),
    .i_rx_byte       (rx_byte),
    .i_tx_word       (i_uart_data_tx),
    .i_tx_word_valid (i_uart_data_tx_valid),
    .i_tx_done       (tx_done),
    .o_cmd           (o_uart_data_rx),
    .o_cmd_valid     (o_uart_data_rx_valid),
    .o_tx_word_ready (o_uart_data_tx_ready),
    .o_tx_dv         (tx_dv),
    .o_tx_byte       (tx_byte)
  );

  uart_tx #(.CLKS_PER_BIT(clks_per_bit)) u_tx (
    .i_CLK     (i_CLK),
    .i_RST     (i_RST),
    .i_tx_dv   (tx_dv),
    .i_tx_byte (tx_byte),
    .o_txd     (o_uart_txd),
    .o_tx_done (tx_done)
  );

endmodule

//--- design/uart_controller.sv
/*
  host link controller
  - host path: filters command bytes by core busy level, builds command word
  - core path: takes a 32-bit word, sends 3 or 4 bytes MSB first by its mark
*/
module uart_controller (
  input  logic                      i_CLK,
  input  logic                      i_RST,
  input  logic                      i_core_busy,
  input  logic                      i_rx_dv,
  input  uart_link_pkg::uart_byte_t i_rx_byte,
  input  uart_link_pkg::core_word_t i_tx_word,
  input  logic                      i_tx_word_valid,
  input  logic                      i_tx_done,
  output uart_link_pkg::cmd_word_t  o_cmd,
  output logic                      o_cmd_valid,
  output logic                      o_tx_word_ready,
  output logic                      o_tx_dv,
  output uart_link_pkg::uart_byte_t o_tx_byte
);

  import uart_link_pkg::*;

  ctrl_state_t r_state;
  core_word_t  r_shift;   // frame word, top byte goes out next
  logic [2:0]  r_remain;  // bytes left in the frame
  logic        r_rx_pend; // host byte came in while framing
  uart_byte_t  r_rx_hold;

  // ========================================
  // decode
  // ========================================
  logic       rx_go;  // host byte to decode in idle
  uart_byte_t rx_cur;
  logic       busy_cmd, read_cmd;
  logic       accept_cmd, start_read, take_word, addr_in, byte_done;
  uart_byte_t top_byte;

  assign rx_go  = i_rx_dv | r_rx_pend;
  assign rx_cur = r_rx_pend ? r_rx_hold : i_rx_byte; // held byte first

  assign busy_cmd = (rx_cur == sg_stop) || (rx_cur == sg_ads_finish) ||
                    (rx_cur == sg_mpr_finish);
  assign read_cmd = (rx_cur == sg_mpr_read_reg) || (rx_cur == sg_ads_read_reg);

  // busy core: stop/finish only, idle core: run or register read
  assign accept_cmd = (r_state == st_idle) && rx_go &&
                      (i_core_busy ? busy_cmd : (rx_cur == sg_run));
  assign start_read = (r_state == st_idle) && rx_go && !i_core_busy && read_cmd;
  assign take_word  = (r_state == st_idle) && !rx_go && i_tx_word_valid; // rx wins
  assign addr_in    = (r_state == st_read_addr) && i_rx_dv;
  assign byte_done  = (r_state == st_wait_done) && i_tx_done;
  assign top_byte   = r_shift[31:24];

  // ========================================
  // control
  // ========================================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_state         <= st_idle;
      r_remain        <= '0;
      r_rx_pend       <= 1'b0;
      o_tx_word_ready <= 1'b0; // rises once idle is reached
      o_cmd_valid     <= 1'b0;
      o_tx_dv         <= 1'b0;
    end else begin
      o_cmd_valid <= 1'b0; // both strobes are single cycle
      o_tx_dv     <= 1'b0;
      if (i_rx_dv && r_state != st_idle && r_state != st_read_addr) r_rx_pend <= 1'b1;
      else if (r_state == st_idle) r_rx_pend <= 1'b0; // consumed this cycle
      case (r_state)
        st_idle: begin
          o_tx_word_ready <= 1'b1;
          if (accept_cmd) o_cmd_valid <= 1'b1;
          else if (start_read) r_state <= st_read_addr;
          else if (take_word) begin
            o_tx_word_ready <= 1'b0; // word taken, core may drop valid
            r_state         <= st_frame_init;
          end
        end
        st_read_addr: begin
          if (addr_in) begin
            o_cmd_valid <= 1'b1;
            r_state     <= st_idle;
          end
        end
        st_frame_init: begin
          if (top_byte == sg_ads_send_data) begin
            r_remain <= frame_len_long;
            r_state  <= st_send_byte;
          end else if (top_byte == sg_mpr_send_data || top_byte == sg_mpr_read_reg ||
                       top_byte == sg_ads_read_reg) begin
            r_remain <= frame_len_short;
            r_state  <= st_send_byte;
          end else r_state <= st_idle; // unknown mark, word dropped
        end
        st_send_byte: begin
          o_tx_dv <= 1'b1;
          r_state <= st_wait_done;
        end
        st_wait_done: begin
          if (byte_done) begin
            if (r_remain == 3'd1) begin
              o_tx_word_ready <= 1'b1; // frame finished
              r_state         <= st_idle;
            end else begin
              r_remain <= r_remain - 3'd1;
              r_state  <= st_send_byte;
            end
          end
        end
        default: r_state <= st_idle;
      endcase
    end
  end

  // ========================================
  // datapath
  // ========================================
  always_ff @(posedge i_CLK) begin
    if (i_rx_dv) r_rx_hold <= i_rx_byte;
    if (accept_cmd || start_read) o_cmd <= {rx_cur, 8'h00}; // address filled in later
    else if (addr_in) o_cmd[7:0] <= i_rx_byte;
    if (take_word) r_shift <= i_tx_word;
    else if (byte_done) r_shift <= r_shift << 8; // next byte to the top
    if (r_state == st_send_byte) o_tx_byte <= top_byte;
  end

endmodule

//--- design/uart_tx.sv
/*
  8N1 serial transmitter
  byte latched on the strobe, start + 8 data (LSB first) + stop,
  done pulse after the stop bit
*/
module uart_tx #(
  parameter logic [15:0] CLKS_PER_BIT = uart_link_pkg::clks_per_bit
) (
  input  logic                      i_CLK,
  input  logic                      i_RST,
  input  logic                      i_tx_dv,
  input  uart_link_pkg::uart_byte_t i_tx_byte,
  output logic                      o_txd,
  output logic                      o_tx_done
);

  import uart_link_pkg::*;

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_t;

  tx_state_t   r_state;
  logic [15:0] r_clk_cnt;
  logic [2:0]  r_bit_idx;
  uart_byte_t  r_data; // byte being sent

  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_state   <= tx_idle;
      r_clk_cnt <= '0;
      r_bit_idx <= '0;
      o_txd     <= 1'b1; // mark level
      o_tx_done <= 1'b0;
    end else begin
      o_tx_done <= 1'b0;
      case (r_state)
        tx_idle: begin
          r_clk_cnt <= '0;
          r_bit_idx <= '0;
          o_txd     <= 1'b1;
          if (i_tx_dv) begin
            o_txd   <= 1'b0; // start bit from the next clock on
            r_state <= tx_start;
          end
        end
        tx_start: begin
          if (r_clk_cnt == CLKS_PER_BIT - 16'd1) begin
            r_clk_cnt <= '0;
            o_txd     <= r_data[0];
            r_state   <= tx_data;
          end else r_clk_cnt <= r_clk_cnt + 16'd1;
        end
        tx_data: begin
          if (r_clk_cnt == CLKS_PER_BIT - 16'd1) begin
            r_clk_cnt <= '0;
            if (r_bit_idx == 3'd7) begin
              o_txd   <= 1'b1; // stop bit
              r_state <= tx_stop;
            end else begin
              r_bit_idx <= r_bit_idx + 3'd1;
              o_txd     <= r_data[r_bit_idx + 3'd1]; // next bit, set at the boundary
            end
          end else r_clk_cnt <= r_clk_cnt + 16'd1;
        end
        tx_stop: begin
          if (r_clk_cnt == CLKS_PER_BIT - 16'd1) begin
            o_tx_done <= 1'b1;
            r_state   <= tx_idle;
          end else r_clk_cnt <= r_clk_cnt + 16'd1;
        end
        default: r_state <= tx_idle;
      endcase
    end
  end

  always_ff @(posedge i_CLK) begin
    if (r_state == tx_idle && i_tx_dv) r_data <= i_tx_byte;
  end

endmodule

//--- design/uart_rx.sv
/*
  8N1 serial receiver
  two-flop input sync, mid-bit sampling,
  one-cycle valid pulse per byte with a good stop bit
*/
module uart_rx #(
  parameter logic [15:0] CLKS_PER_BIT = uart_link_pkg::clks_per_bit
) (
  input  logic                    i_CLK,
  input  logic                    i_RST,
  input  logic                    i_rxd,
  output logic                    o_rx_dv,
  output uart_link_pkg::uart_byte_t o_rx_byte
);

  typedef enum logic [2:0] {
    rx_idle,
    rx_start, // confirm start bit at its midpoint
    rx_data,
    rx_stop,
    rx_tail   // half bit past stop midpoint, then report
  } rx_state_t;

  rx_state_t   r_state;
  logic        r_rxd_meta;
  logic        r_rxd_sync;
  logic [15:0] r_clk_cnt; // clocks within current bit
  logic [2:0]  r_bit_cnt; // data bit index
  logic        r_stop_ok; // stop bit sampled high

  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_rxd_meta <= 1'b1; // line idles high
      r_rxd_sync <= 1'b1;
      r_state    <= rx_idle;
      r_clk_cnt  <= '0;
      r_bit_cnt  <= '0;
      r_stop_ok  <= 1'b0;
      o_rx_dv    <= 1'b0;
    end else begin
      r_rxd_meta <= i_rxd;
      r_rxd_sync <= r_rxd_meta;
      o_rx_dv    <= 1'b0; // pulse only
      case (r_state)
        rx_idle: begin
          r_clk_cnt <= '0;
          r_bit_cnt <= '0;
          if (!r_rxd_sync) r_state <= rx_start; // falling edge, possible start
        end
        rx_start: begin
          if (r_clk_cnt == ((CLKS_PER_BIT - 16'd1) >> 1)) begin
            r_clk_cnt <= '0;
            r_state   <= r_rxd_sync ? rx_idle : rx_data; // glitch -> back to idle
          end else r_clk_cnt <= r_clk_cnt + 16'd1;
        end
        rx_data: begin
          if (r_clk_cnt == CLKS_PER_BIT - 16'd1) begin // data bit midpoint
            r_clk_cnt <= '0;
            r_bit_cnt <= r_bit_cnt + 3'd1;
            if (r_bit_cnt == 3'd7) r_state <= rx_stop;
          end else r_clk_cnt <= r_clk_cnt + 16'd1;
        end
        rx_stop: begin
          if (r_clk_cnt == CLKS_PER_BIT - 16'd1) begin
            r_clk_cnt <= '0;
            r_stop_ok <= r_rxd_sync;
            r_state   <= rx_tail;
          end else r_clk_cnt <= r_clk_cnt + 16'd1;
        end
        rx_tail: begin
          if (r_clk_cnt == ((CLKS_PER_BIT - 16'd1) >> 1)) begin
            o_rx_dv <= r_stop_ok; // bad stop bit, byte dropped silently
            r_state <= rx_idle;
          end else r_clk_cnt <= r_clk_cnt + 16'd1;
        end
        default: r_state <= rx_idle;
      endcase
    end
  end

  // shift register, LSB arrives first
  always_ff @(posedge i_CLK) begin
    if (r_state == rx_data && r_clk_cnt == CLKS_PER_BIT - 16'd1)
      o_rx_byte <= {r_rxd_sync, o_rx_byte[7:1]};
  end

endmodule

//--- design/uart_link_pkg.sv
/*
  shared definitions for the host-link UART
  - bit period, host command bytes, frame marks, frame lengths
  - byte / core word / command word types
  - controller state encoding
*/
package uart_link_pkg;

  // ========================================
  // serial timing
  // ========================================
  localparam logic [15:0] clks_per_bit = 16'd16; // sim value, 25MHz/115200 on the board

  // ========================================
  // host command bytes
  // ========================================
  localparam logic [7:0] sg_run          = 8'h52; // 'R'
  localparam logic [7:0] sg_stop         = 8'h53; // 'S'
  localparam logic [7:0] sg_ads_finish   = 8'h46; // 'F'
  localparam logic [7:0] sg_mpr_finish   = 8'h66; // 'f'
  localparam logic [7:0] sg_mpr_read_reg = 8'h6D; // 'm', address byte follows
  localparam logic [7:0] sg_ads_read_reg = 8'h61; // 'a', address byte follows

  // core word marks, top byte of the word
  localparam logic [7:0] sg_ads_send_data = 8'hAA; // adc sample, 4 byte frame
  localparam logic [7:0] sg_mpr_send_data = 8'hBB; // pressure sample, 3 byte frame

  localparam logic [2:0] frame_len_long  = 3'd4;
  localparam logic [2:0] frame_len_short = 3'd3;

  // ========================================
  // types
  // ========================================
  typedef logic [7:0]  uart_byte_t; // one serial byte
  typedef logic [31:0] core_word_t; // word from the sensor core
  typedef logic [15:0] cmd_word_t;  // {command byte, address or 0}

  typedef enum logic [2:0] {
    st_idle,       // decode host bytes, take core words
    st_read_addr,  // register read, waiting for address byte
    st_frame_init, // pick frame length from mark
    st_send_byte,  // strobe next byte into tx
    st_wait_done   // wait for tx to finish the byte
  } ctrl_state_t;

endpackage
